//--- verification/cam_tracker_golden.txt
// columns: orange col start, col end, row mask (bit n = row n), orange pixel RGB444,
// expected direction (0 none, 1 left, 2 center, 3 right), expected detected flag
0 2 f e80 1 1 // left block
5 6 3 c40 2 1 // center block
9 b 6 f64 3 1 // right block
2 5 1 ca4 2 1 // left-center tie
8 9 1 d70 0 0 // two hits only
0 b f b80 0 0 // red just below bound
0 b f c30 0 0 // green just below bound
0 b f cb0 0 0 // green just above bound
0 b f c85 0 0 // blue just above bound
3 5 8 ca4 2 1 // exactly min_hits, center heavier
6 9 2 e60 2 1 // center-right tie
7 b c f64 3 1 // right beats center
0 b f fa4 2 1 // three-way tie
0 0 0 e80 0 0 // empty mask
1 4 f d50 1 1 // left beats center
b b 7 c44 3 1 // lower corner colour, three hits
6 6 f e80 2 1 // single center column
a b f fa0 3 1 // right edge
0 0 7 fa0 1 1 // left edge, three hits
4 4 1 e60 0 0 // one hit

//--- cam_tracker.f
common/cam_pkg.sv
design/frame_store/frame_store_ram.sv
design/frame_store/frame_store_arbiter.sv
design/pixel_capture.sv
design/scan_reader.sv
design/orange_classifier.sv
design/cam_tracker.sv
verification/cam_tracker_props.sv
verification/cam_tracker_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the tracker testbench with Verilator, runs it and searches the log for the fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --assert -Wno-fatal --top-module cam_tracker_tb \
  -f cam_tracker.f -o sim_cam_tracker \
  && ./obj_dir/sim_cam_tracker +verilator+error+limit+100 2>&1 | tee "$log" \
  || { echo "build or simulation run failed"; exit 1; }

grep -q "=== FAIL ===" "$log" && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" "$log" || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- verification/cam_tracker_tb.sv
// testbench for the tracker, drives golden frames through the camera port and checks the outputs
module cam_tracker_tb;
  import cam_pkg::*;

  localparam int frame_w         = 12;
  localparam int frame_h         = 4;
  localparam int min_hits        = 3;
  localparam int npix            = frame_w * frame_h;
  localparam int num_frames      = 20;
  localparam int fields          = 6;
  localparam int watchdog_cycles = 4 * num_frames * npix * 5;

  logic              clk_25_vga;
  logic              rst;
  logic              cam_vsync;
  logic              cam_href;
  logic              cam_byte_valid;
  logic [7:0]        cam_data;
  logic              scan_start;
  logic              pix_valid;
  logic [chan_w-1:0] pix_r;
  logic [chan_w-1:0] pix_g;
  logic [chan_w-1:0] pix_b;
  logic              pix_last;
  logic              dir_valid;
  dir_e              direction;
  logic              target_detected;

  // golden rows with six fields per frame
  logic [11:0]      golden [0:fields*num_frames-1];
  // tb copy of the frame held in the store
  logic [pix_w-1:0] img [0:npix-1];
  logic [31:0]      lcg_state;
  int               bin_l;
  int               bin_c;
  int               bin_r;
  int               pix_errors;
  int               ctl_errors;
  int               dir_errors;
  int               gold_errors;

  cam_tracker #(
    .frame_w (frame_w),
    .frame_h (frame_h),
    .min_hits(min_hits)
  ) i_dut (
    .clk_25_vga     (clk_25_vga),
    .rst            (rst),
    .cam_vsync      (cam_vsync),
    .cam_href       (cam_href),
    .cam_byte_valid (cam_byte_valid),
    .cam_data       (cam_data),
    .scan_start     (scan_start),
    .pix_valid      (pix_valid),
    .pix_r          (pix_r),
    .pix_g          (pix_g),
    .pix_b          (pix_b),
    .pix_last       (pix_last),
    .dir_valid      (dir_valid),
    .direction      (direction),
    .target_detected(target_detected)
  );

  always #2 clk_25_vga = ~clk_25_vga;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // orange window straight from the colour thresholds
  function automatic logic orange_hit(input logic [11:0] p);
    return (p[11:8] >= orange_r_min) && (p[7:4] >= orange_g_min) &&
           (p[7:4] <= orange_g_max) && (p[3:0] <= orange_b_max);
  endfunction

  function automatic logic [23:0] expected_rgb(input logic [11:0] p);
    if (orange_hit(p)) begin
      return marker_rgb;
    end
    // each nibble doubled up to 8 bits
    return {p[11:8], p[11:8], p[7:4], p[7:4], p[3:0], p[3:0]};
  endfunction

  // biggest bin wins with ties going to center then left
  function automatic dir_e predict_direction(input int l, input int c, input int r);
    int peak;
    if (l + c + r < min_hits) begin
      return dir_none;
    end
    peak = (l > c) ? l : c;
    peak = (r > peak) ? r : peak;
    if (c == peak) begin
      return dir_center;
    end else if (l == peak) begin
      return dir_left;
    end
    return dir_right;
  endfunction

  // orange rectangle over lcg background with bins counted on the way
  task automatic build_image(input int fi);
    int cs;
    int ce;
    int idx;
    logic [3:0]  mask;
    logic [11:0] opix;
    cs    = golden[fields*fi];
    ce    = golden[fields*fi+1];
    mask  = golden[fields*fi+2][3:0];
    opix  = golden[fields*fi+3];
    bin_l = 0;
    bin_c = 0;
    bin_r = 0;
    for (int r = 0; r < frame_h; r++) begin
      for (int c = 0; c < frame_w; c++) begin
        idx       = r * frame_w + c;
        lcg_state = lcg_step(lcg_state);
        if (c >= cs && c <= ce && mask[r]) begin
          img[idx] = opix;
        end else begin
          // red top bit cleared so background is never orange
          img[idx] = lcg_state[27:16] & 12'h7ff;
        end
        if (orange_hit(img[idx])) begin
          if (c < frame_w / 3) begin
            bin_l++;
          end else if (c >= (2 * frame_w) / 3) begin
            bin_r++;
          end else begin
            bin_c++;
          end
        end
      end
    end
  endtask

  task automatic send_byte(input logic [7:0] d, input logic href);
    @(negedge clk_25_vga);
    cam_vsync      = 1'b0;
    cam_href       = href;
    cam_byte_valid = 1'b1;
    cam_data       = d;
  endtask

  task automatic end_line();
    @(negedge clk_25_vga);
    cam_href       = 1'b0;
    cam_byte_valid = 1'b0;
    @(negedge clk_25_vga);
  endtask

  task automatic start_camera_frame();
    @(negedge clk_25_vga);
    cam_vsync      = 1'b1;
    cam_href       = 1'b0;
    cam_byte_valid = 1'b0;
    @(negedge clk_25_vga);
    cam_vsync = 1'b0;
  endtask

  // whole frame from img with optional href-low junk inside each pair
  task automatic send_frame(input bit with_noise);
    logic [11:0] p;
    start_camera_frame();
    for (int r = 0; r < frame_h; r++) begin
      for (int c = 0; c < frame_w; c++) begin
        p = img[r * frame_w + c];
        send_byte({4'h0, p[11:8]}, 1'b1);
        if (with_noise) begin
          send_byte(~p[7:0], 1'b0);
        end
        send_byte(p[7:0], 1'b1);
      end
      end_line();
    end
  endtask

  // a few junk pixels and a dangling byte cut off by the next vsync
  task automatic send_partial_frame();
    start_camera_frame();
    for (int k = 0; k < 7; k++) begin
      lcg_state = lcg_step(lcg_state);
      send_byte(lcg_state[23:16], 1'b1);
      send_byte(lcg_state[31:24], 1'b1);
    end
    send_byte(8'h0f, 1'b1);
    end_line();
  endtask

  task automatic scan_and_check(input int fi, input dir_e exp_dir, input logic exp_det);
    int          seen;
    logic [23:0] exp_rgb;
    logic [23:0] got_rgb;
    @(negedge clk_25_vga);
    scan_start = 1'b1;
    @(negedge clk_25_vga);
    scan_start = 1'b0;
    seen = 0;
    while (seen < npix) begin
      @(negedge clk_25_vga);
      if (pix_valid) begin
        exp_rgb = expected_rgb(img[seen]);
        got_rgb = {pix_r, pix_g, pix_b};
        assert (got_rgb == exp_rgb) else begin
          pix_errors++;
          $display("Fail t=%0t pix_rgb expected %06h actual %06h (frame %0d pixel %0d)",
                   $time, exp_rgb, got_rgb, fi, seen);
        end
        assert (pix_last == (seen == npix - 1)) else begin
          ctl_errors++;
          $display("Fail t=%0t pix_last expected %0b actual %0b (frame %0d pixel %0d)",
                   $time, seen == npix - 1, pix_last, fi, seen);
        end
        seen++;
      end
    end
    // result lands the cycle after pix_last
    @(negedge clk_25_vga);
    assert (dir_valid) else begin
      ctl_errors++;
      $display("Fail t=%0t dir_valid expected 1 actual 0 (frame %0d)", $time, fi);
    end
    assert (direction == exp_dir && target_detected == exp_det) else begin
      dir_errors++;
      $display("Fail t=%0t direction expected %0d/%0b actual %0d/%0b (frame %0d)",
               $time, exp_dir, exp_det, direction, target_detected, fi);
    end
    // single pulses only and the result must hold
    repeat (6) begin
      @(negedge clk_25_vga);
      assert (!pix_valid && !dir_valid && direction == exp_dir &&
              target_detected == exp_det) else begin
        ctl_errors++;
        $display("frame %0d: extra video or result pulse, or result changed after frame end", fi);
      end
    end
  endtask

  initial begin
    int   arb_errors;
    int   total;
    dir_e gold_dir;
    logic gold_det;
    clk_25_vga     = 1'b0;
    rst            = 1'b1;
    cam_vsync      = 1'b0;
    cam_href       = 1'b0;
    cam_byte_valid = 1'b0;
    cam_data       = 8'h00;
    scan_start     = 1'b0;
    lcg_state      = 32'd86;
    pix_errors     = 0;
    ctl_errors     = 0;
    dir_errors     = 0;
    gold_errors    = 0;
    $readmemh("verification/cam_tracker_golden.txt", golden);
    repeat (10) @(posedge clk_25_vga);
    @(negedge clk_25_vga);
    rst = 1'b0;
    @(negedge clk_25_vga);
    assert (!pix_valid && !dir_valid && !target_detected && direction == dir_none) else begin
      ctl_errors++;
      $display("outputs not in their reset state after reset");
    end
    for (int fi = 0; fi < num_frames; fi++) begin
      build_image(fi);
      gold_dir = dir_e'(golden[fields*fi+4][1:0]);
      gold_det = golden[fields*fi+5][0];
      assert (gold_dir == predict_direction(bin_l, bin_c, bin_r) &&
              gold_det == (bin_l + bin_c + bin_r >= min_hits)) else begin
        gold_errors++;
        $display("golden row %0d disagrees with the bin rule (bins %0d %0d %0d)",
                 fi, bin_l, bin_c, bin_r);
      end
      // every third frame gets a broken start and href-low junk
      if (fi % 3 == 2) begin
        send_partial_frame();
      end
      send_frame(fi % 3 == 2);
      repeat (3) @(negedge clk_25_vga);
      // odd frames are rewritten while the scan runs, so writes hit reads
      if (fi % 2 == 1) begin
        fork
          send_frame(1'b0);
          scan_and_check(fi, gold_dir, gold_det);
        join
      end else begin
        scan_and_check(fi, gold_dir, gold_det);
      end
    end
    arb_errors = i_dut.i_frame_store_arbiter.i_arb_props.err_rd +
                 i_dut.i_frame_store_arbiter.i_arb_props.err_we +
                 i_dut.i_frame_store_arbiter.i_arb_props.err_wr;
    total = pix_errors + ctl_errors + dir_errors + gold_errors + arb_errors;
    $display("errors: pixel %0d, control %0d, direction %0d, golden %0d, arbiter %0d",
             pix_errors, ctl_errors, dir_errors, gold_errors, arb_errors);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk_25_vga);
    $display("watchdog expired after %0d cycles, the DUT stopped delivering video",
             watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- verification/cam_tracker_props.sv
// concurrent checks on the frame store arbiter, bound into every arbiter instance
module cam_tracker_props (
  input logic clk_25_vga,
  input logic rst,
  input logic wr_req,
  input logic rd_req,
  input logic rd_valid,
  input logic ram_we
);

  // failure counts per property
  int err_rd = 0;
  int err_we = 0;
  int err_wr = 0;

  // data comes back 2 cycles after a clean read, 3 after a held one
  rd_after_req: assert property (@(posedge clk_25_vga) disable iff (rst)
    rd_valid |-> ($past(rd_req, 2) || $past(rd_req, 3)))
    else begin
      err_rd = err_rd + 1;
      $error("rd_valid without a matching rd_req");
    end

  // write goes to the ram in its own cycle
  we_follows_req: assert property (@(posedge clk_25_vga) disable iff (rst)
    ram_we == wr_req)
    else begin
      err_we = err_we + 1;
      $error("ram_we differs from wr_req");
    end

  wr_spaced: assert property (@(posedge clk_25_vga) disable iff (rst)
    wr_req |=> !wr_req)
    else begin
      err_wr = err_wr + 1;
      $error("wr_req high in two consecutive cycles");
    end

endmodule

bind frame_store_arbiter cam_tracker_props i_arb_props (
  .clk_25_vga(clk_25_vga),
  .rst       (rst),
  .wr_req    (wr_req),
  .rd_req    (rd_req),
  .rd_valid  (rd_valid),
  .ram_we    (ram_we)
);

//--- design/cam_tracker.sv
// top level of the tracker, camera capture into the frame store and classified readout
module cam_tracker #(
  parameter int frame_w  = 12,
  parameter int frame_h  = 4,
  parameter int min_hits = 3
) (
  input  logic                       clk_25_vga,
  input  logic                       rst,
  input  logic                       cam_vsync,
  input  logic                       cam_href,
  input  logic                       cam_byte_valid,
  input  logic [7:0]                 cam_data,
  input  logic                       scan_start,
  output logic                       pix_valid,
  output logic [cam_pkg::chan_w-1:0] pix_r,
  output logic [cam_pkg::chan_w-1:0] pix_g,
  output logic [cam_pkg::chan_w-1:0] pix_b,
  output logic                       pix_last,
  output logic                       dir_valid,
  output cam_pkg::dir_e              direction,
  output logic                       target_detected
);
  import cam_pkg::*;

  localparam int addr_w = $clog2(frame_w * frame_h);
  localparam int col_w  = $clog2(frame_w);

  // capture to arbiter
  logic              wr_req;
  logic [addr_w-1:0] wr_addr;
  logic [pix_w-1:0]  wr_data;
  // reader and arbiter
  logic              rd_req;
  logic [addr_w-1:0] rd_addr;
  logic              rd_valid;
  logic [pix_w-1:0]  rd_data;
  // arbiter to memory
  logic              ram_we;
  logic [addr_w-1:0] ram_addr;
  logic [pix_w-1:0]  ram_wdata;
  logic [pix_w-1:0]  ram_rdata;
  // scanned pixels
  logic              sp_valid;
  logic [pix_w-1:0]  sp_data;
  logic [col_w-1:0]  sp_col;
  logic              sp_last;

  pixel_capture #(
    .frame_w(frame_w),
    .frame_h(frame_h),
    .addr_w (addr_w)
  ) i_pixel_capture (
    .clk_25_vga    (clk_25_vga),
    .rst           (rst),
    .cam_vsync     (cam_vsync),
    .cam_href      (cam_href),
    .cam_byte_valid(cam_byte_valid),
    .cam_data      (cam_data),
    .wr_req        (wr_req),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data)
  );

  frame_store_arbiter #(
    .addr_w(addr_w)
  ) i_frame_store_arbiter (
    .clk_25_vga(clk_25_vga),
    .rst       (rst),
    .wr_req    (wr_req),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

  frame_store_ram #(
    .frame_w(frame_w),
    .frame_h(frame_h),
    .addr_w (addr_w)
  ) i_frame_store_ram (
    .clk_25_vga(clk_25_vga),
    .we        (ram_we),
    .addr      (ram_addr),
    .wdata     (ram_wdata),
    .rdata     (ram_rdata)
  );

  scan_reader #(
    .frame_w(frame_w),
    .frame_h(frame_h),
    .addr_w (addr_w)
  ) i_scan_reader (
    .clk_25_vga(clk_25_vga),
    .rst       (rst),
    .scan_start(scan_start),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .sp_valid  (sp_valid),
    .sp_data   (sp_data),
    .sp_col    (sp_col),
    .sp_last   (sp_last)
  );

  orange_classifier #(
    .frame_w (frame_w),
    .min_hits(min_hits)
  ) i_orange_classifier (
    .clk_25_vga     (clk_25_vga),
    .rst            (rst),
    .sp_valid       (sp_valid),
    .sp_data        (sp_data),
    .sp_col         (sp_col),
    .sp_last        (sp_last),
    .pix_valid      (pix_valid),
    .pix_r          (pix_r),
    .pix_g          (pix_g),
    .pix_b          (pix_b),
    .pix_last       (pix_last),
    .dir_valid      (dir_valid),
    .direction      (direction),
    .target_detected(target_detected)
  );

endmodule

//--- design/orange_classifier.sv
// marks orange pixels in the output video and picks a steering direction per frame
module orange_classifier #(
  parameter int  frame_w  = 12,
  parameter int  min_hits = 3,
  localparam int col_w    = $clog2(frame_w)
) (
  input  logic                       clk_25_vga,
  input  logic                       rst,
  input  logic                       sp_valid,
  input  logic [cam_pkg::pix_w-1:0]  sp_data,
  input  logic [col_w-1:0]           sp_col,
  input  logic                       sp_last,
  output logic                       pix_valid,
  output logic [cam_pkg::chan_w-1:0] pix_r,
  output logic [cam_pkg::chan_w-1:0] pix_g,
  output logic [cam_pkg::chan_w-1:0] pix_b,
  output logic                       pix_last,
  output logic                       dir_valid,
  output cam_pkg::dir_e              direction,
  output logic                       target_detected
);
  import cam_pkg::*;

  // bin counter width
  localparam int cnt_w     = 16;
  localparam int left_end  = frame_w / 3;
  localparam int right_beg = (2 * frame_w) / 3;

  logic [nibble_w-1:0] nib_r;
  logic [nibble_w-1:0] nib_g;
  logic [nibble_w-1:0] nib_b;
  logic                is_orange;
  logic [cnt_w-1:0]    bin_left;
  logic [cnt_w-1:0]    bin_center;
  logic [cnt_w-1:0]    bin_right;
  logic [cnt_w+1:0]    hit_total;
  dir_e                next_dir;
  logic                next_det;

  assign nib_r = sp_data[3*nibble_w-1:2*nibble_w];
  assign nib_g = sp_data[2*nibble_w-1:nibble_w];
  assign nib_b = sp_data[nibble_w-1:0];

  // orange window test
  assign is_orange = (nib_r >= orange_r_min) &&
                     (nib_g >= orange_g_min) && (nib_g <= orange_g_max) &&
                     (nib_b <= orange_b_max);

  // registered video path
  always_ff @(posedge clk_25_vga) begin
    if (sp_valid) begin
      if (is_orange) begin
        {pix_r, pix_g, pix_b} <= marker_rgb;
      end else begin
        // nibble repeat stretches 0..15 onto 0..255
        pix_r <= {nib_r, nib_r};
        pix_g <= {nib_g, nib_g};
        pix_b <= {nib_b, nib_b};
      end
    end
  end

  // frame decision from the bins
  always_comb begin
    hit_total = (cnt_w + 2)'(bin_left) + (cnt_w + 2)'(bin_center) + (cnt_w + 2)'(bin_right);
    next_det  = 1'b1;
    if (hit_total < min_hits) begin
      next_dir = dir_none;
      next_det = 1'b0;
    end else if (bin_center >= bin_left && bin_center >= bin_right) begin
      // center takes every tie it is part of
      next_dir = dir_center;
    end else if (bin_left >= bin_right) begin
      next_dir = dir_left;
    end else begin
      next_dir = dir_right;
    end
  end

  always_ff @(posedge clk_25_vga) begin
    if (rst) begin
      pix_valid       <= 1'b0;
      pix_last        <= 1'b0;
      dir_valid       <= 1'b0;
      direction       <= dir_none;
      target_detected <= 1'b0;
      bin_left        <= '0;
      bin_center      <= '0;
      bin_right       <= '0;
    end else begin
      pix_valid <= sp_valid;
      pix_last  <= sp_valid & sp_last;
      dir_valid <= pix_last;
      if (pix_last) begin
        // last pixel already counted so publish and clear
        direction       <= next_dir;
        target_detected <= next_det;
        bin_left        <= '0;
        bin_center      <= '0;
        bin_right       <= '0;
      end else if (sp_valid && is_orange) begin
        if (sp_col < left_end) begin
          bin_left <= bin_left + 1'b1;
        end else if (sp_col >= right_beg) begin
          bin_right <= bin_right + 1'b1;
        end else begin
          bin_center <= bin_center + 1'b1;
        end
      end
    end
  end

endmodule

//--- design/scan_reader.sv
// reads the stored frame back in raster order, one outstanding read at a time
module scan_reader #(
  parameter int  frame_w = 12,
  parameter int  frame_h = 4,
  parameter int  addr_w  = 6,
  localparam int col_w   = $clog2(frame_w)
) (
  input  logic                      clk_25_vga,
  input  logic                      rst,
  input  logic                      scan_start,
  output logic                      rd_req,
  output logic [addr_w-1:0]         rd_addr,
  input  logic                      rd_valid,
  input  logic [cam_pkg::pix_w-1:0] rd_data,
  output logic                      sp_valid,
  output logic [cam_pkg::pix_w-1:0] sp_data,
  output logic [col_w-1:0]          sp_col,
  output logic                      sp_last
);

  localparam logic [addr_w-1:0] last_addr = addr_w'(frame_w * frame_h - 1);
  localparam logic [col_w-1:0]  last_col  = col_w'(frame_w - 1);

  typedef enum logic [1:0] {
    scan_idle,
    scan_request,
    scan_wait
  } scan_state_e;

  scan_state_e         state;
  logic [addr_w-1:0]   addr_q;
  logic [col_w-1:0]    col_q;

  // request lasts exactly the one cycle spent in scan_request
  assign rd_req  = (state == scan_request);
  assign rd_addr = addr_q;

  always_ff @(posedge clk_25_vga) begin
    if (rst) begin
      state    <= scan_idle;
      addr_q   <= '0;
      col_q    <= '0;
      sp_valid <= 1'b0;
      sp_last  <= 1'b0;
    end else begin
      sp_valid <= 1'b0;
      sp_last  <= 1'b0;
      case (state)
        scan_idle: begin
          // start strobes during a scan never reach here
          if (scan_start) begin
            addr_q <= '0;
            col_q  <= '0;
            state  <= scan_request;
          end
        end
        scan_request: begin
          state <= scan_wait;
        end
        scan_wait: begin
          if (rd_valid) begin
            sp_valid <= 1'b1;
            sp_last  <= (addr_q == last_addr);
            if (addr_q == last_addr) begin
              state <= scan_idle;
            end else begin
              addr_q <= addr_q + 1'b1;
              // column follows the raster
              col_q  <= (col_q == last_col) ? '0 : col_q + 1'b1;
              state  <= scan_request;
            end
          end
        end
        default: state <= scan_idle;
      endcase
    end
  end

  // pixel and its column ride along with sp_valid
  always_ff @(posedge clk_25_vga) begin
    if (state == scan_wait && rd_valid) begin
      sp_data <= rd_data;
      sp_col  <= col_q;
    end
  end

endmodule

//--- design/pixel_capture.sv
// packs camera byte pairs into RGB444 pixels and writes them at raster addresses
module pixel_capture #(
  parameter int frame_w = 12,
  parameter int frame_h = 4,
  parameter int addr_w  = 6
) (
  input  logic                      clk_25_vga,
  input  logic                      rst,
  input  logic                      cam_vsync,
  input  logic                      cam_href,
  input  logic                      cam_byte_valid,
  input  logic [7:0]                cam_data,
  output logic                      wr_req,
  output logic [addr_w-1:0]         wr_addr,
  output logic [cam_pkg::pix_w-1:0] wr_data
);
  import cam_pkg::*;

  localparam logic [addr_w-1:0] last_addr = addr_w'(frame_w * frame_h - 1);

  // byte only counts inside an active line
  logic                byte_ok;
  // high while waiting for the second byte
  logic                phase;
  logic [addr_w-1:0]   addr_q;
  // red nibble from the first byte
  logic [nibble_w-1:0] red_hold;

  assign byte_ok = cam_byte_valid & cam_href;

  always_ff @(posedge clk_25_vga) begin
    if (rst) begin
      phase  <= 1'b0;
      addr_q <= '0;
      wr_req <= 1'b0;
    end else begin
      wr_req <= 1'b0;
      if (cam_vsync) begin
        // new frame, restart at top-left
        phase  <= 1'b0;
        addr_q <= '0;
      end else if (byte_ok) begin
        phase <= ~phase;
        if (phase) begin
          wr_req <= 1'b1;
          if (addr_q == last_addr) begin
            addr_q <= '0;
          end else begin
            addr_q <= addr_q + 1'b1;
          end
        end
      end
    end
  end

  // pixel payload
  always_ff @(posedge clk_25_vga) begin
    if (!cam_vsync && byte_ok) begin
      if (!phase) begin
        red_hold <= cam_data[nibble_w-1:0];
      end else begin
        // second byte brings green in the high nibble, blue in the low
        wr_data <= {red_hold, cam_data};
        wr_addr <= addr_q;
      end
    end
  end

endmodule

//--- design/frame_store/frame_store_arbiter.sv
// shares the frame memory port between capture writes and scan reads, write has priority
module frame_store_arbiter #(
  parameter int addr_w = 6
) (
  input  logic                      clk_25_vga,
  input  logic                      rst,
  input  logic                      wr_req,
  input  logic [addr_w-1:0]         wr_addr,
  input  logic [cam_pkg::pix_w-1:0] wr_data,
  input  logic                      rd_req,
  input  logic [addr_w-1:0]         rd_addr,
  output logic                      rd_valid,
  output logic [cam_pkg::pix_w-1:0] rd_data,
  output logic                      ram_we,
  output logic [addr_w-1:0]         ram_addr,
  output logic [cam_pkg::pix_w-1:0] ram_wdata,
  input  logic [cam_pkg::pix_w-1:0] ram_rdata
);

  // one-entry holding slot for a read that lost to a write
  logic              pend_valid;
  logic [addr_w-1:0] pend_addr;
  // ram was read last cycle so rdata holds the word
  logic              rd_issued;

  // write never waits
  assign ram_we    = wr_req;
  assign ram_wdata = wr_data;

  // port address select
  // a pending read always follows a write cycle, so it never meets another write
  always_comb begin
    if (wr_req) begin
      ram_addr = wr_addr;
    end else if (pend_valid) begin
      ram_addr = pend_addr;
    end else begin
      ram_addr = rd_addr;
    end
  end

  always_ff @(posedge clk_25_vga) begin
    if (rst) begin
      pend_valid <= 1'b0;
      rd_issued  <= 1'b0;
      rd_valid   <= 1'b0;
    end else begin
      // park the read when it collides
      pend_valid <= rd_req & wr_req;
      rd_issued  <= (rd_req & ~wr_req) | pend_valid;
      rd_valid   <= rd_issued;
    end
  end

  // held read address and returned data
  always_ff @(posedge clk_25_vga) begin
    if (rd_req & wr_req) begin
      pend_addr <= rd_addr;
    end
    if (rd_issued) begin
      rd_data <= ram_rdata;
    end
  end

endmodule

//--- design/frame_store/frame_store_ram.sv
// single-port frame memory with registered read, one RGB444 word per pixel
module frame_store_ram #(
  parameter int frame_w = 12,
  parameter int frame_h = 4,
  parameter int addr_w  = 6
) (
  input  logic                     clk_25_vga,
  input  logic                     we,
  input  logic [addr_w-1:0]        addr,
  input  logic [cam_pkg::pix_w-1:0] wdata,
  output logic [cam_pkg::pix_w-1:0] rdata
);
  import cam_pkg::*;

  localparam int depth = frame_w * frame_h;

  // one whole frame
  logic [pix_w-1:0] mem [0:depth-1];

  always_ff @(posedge clk_25_vga) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    // read data lands one cycle after the address
    rdata <= mem[addr];
  end

endmodule

//--- common/cam_pkg.sv
// shared widths, direction type and orange thresholds, imported by the tracker and its testbench
package cam_pkg;

  // stored pixel is RGB444
  localparam int nibble_w = 4;
  localparam int pix_w    = 3 * nibble_w;

  // output video channel width
  localparam int chan_w = 8;

  // steering result reported once per frame
  typedef enum logic [1:0] {
    dir_none   = 2'd0,
    dir_left   = 2'd1,
    dir_center = 2'd2,
    dir_right  = 2'd3
  } dir_e;

  // orange window on the 4-bit channels
  // strong red, moderate green, little blue
  localparam logic [nibble_w-1:0] orange_r_min = 4'd12;
  localparam logic [nibble_w-1:0] orange_g_min = 4'd4;
  localparam logic [nibble_w-1:0] orange_g_max = 4'd10;
  localparam logic [nibble_w-1:0] orange_b_max = 4'd4;

  // pure green painted over detected pixels
  localparam logic [3*chan_w-1:0] marker_rgb = 24'h00ff00;

endpackage
